/* Bender.yml */
package:
  name: mem_wb

sources:
  # rtl, package first
  - include_dirs:
      - hdl
    files:
      - hdl/rv_pkg.sv
      - hdl/store_align.sv
      - hdl/load_align.sv
      - hdl/csr_file.sv
      - hdl/wb_select.sv
      - hdl/data_mem.sv
      - hdl/mem_wb_stage.sv
      - hdl/mem_wb_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/tb_mem_wb.sv

/* build.f */
+incdir+hdl
hdl/rv_pkg.sv
hdl/store_align.sv
hdl/load_align.sv
hdl/csr_file.sv
hdl/wb_select.sv
hdl/data_mem.sv
hdl/mem_wb_stage.sv
hdl/mem_wb_top.sv
verification/tb_mem_wb.sv

/* hdl/csr_file.sv */
// csr file holds the tohost register that csrrw and csrrwi write

`include "rv_params.svh"

module csr_file import rv_pkg::*; (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             advance,
	input  logic [`XLEN-1:0] inst,
	input  logic [`XLEN-1:0] rs1_val,
	output logic [`XLEN-1:0] csr
);

	localparam logic [2:0] F3_CSRRW  = 3'b001;
	localparam logic [2:0] F3_CSRRWI = 3'b101;

	logic             is_rw;
	logic             is_rwi;
	logic             addr_hit;
	logic             wr_en;
	logic [`XLEN-1:0] wr_val;

	assign is_rw    = (opcode_e'(inst[6:0]) == SYSTEM) && (inst[14:12] == F3_CSRRW);
	assign is_rwi   = (opcode_e'(inst[6:0]) == SYSTEM) && (inst[14:12] == F3_CSRRWI);
	assign addr_hit = (inst[31:20] == `CSR_TOHOST_ADDR);
	assign wr_en    = advance && addr_hit && (is_rw || is_rwi);

	// immediate form takes the rs1 field as a 5-bit uimm
	assign wr_val = is_rwi ? {{(`XLEN-5){1'b0}}, inst[19:15]} : rs1_val;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			csr <= '0;
		end else if (wr_en) begin
			csr <= wr_val;
		end
	end

endmodule

/* hdl/data_mem.sv */
// data memory as a one-port word array with byte-enabled write and registered read

`include "rv_params.svh"

module data_mem import rv_pkg::*; (
	input  logic             clk,
	input  dmem_req_t        req,
	output logic [`XLEN-1:0] rdata
);

	localparam int AW = $clog2(`DMEM_WORDS);

	logic [`XLEN-1:0] mem [`DMEM_WORDS];
	logic [AW-1:0]    idx;

	// word index without the byte offset
	assign idx = req.addr[AW+1:2];

	always_ff @(posedge clk) begin
		for (int b = 0; b < 4; b++) begin
			if (req.we[b]) begin
				mem[idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
			end
		end
	end

	// read data holds while re is low
	always_ff @(posedge clk) begin
		if (req.re) begin
			rdata <= mem[idx];
		end
	end

endmodule

/* hdl/load_align.sv */
// load align picks the loaded byte, half or word and extends it per funct3

`include "rv_params.svh"

module load_align import rv_pkg::*; (
	input  logic [`XLEN-1:0] inst,
	input  logic [1:0]       addr_lo,
	input  logic [`XLEN-1:0] raw,
	output logic [`XLEN-1:0] data
);

	load_f3_e         f3;
	logic [`XLEN-1:0] shifted;

	assign f3 = load_f3_e'(inst[14:12]);

	// bring the addressed lane down to bit 0
	assign shifted = raw >> {addr_lo, 3'b000};

	always_comb begin
		case (f3)
			LB: begin
				data = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
			end
			LH: begin
				data = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
			end
			LBU: begin
				data = {{(`XLEN-8){1'b0}}, shifted[7:0]};
			end
			LHU: begin
				data = {{(`XLEN-16){1'b0}}, shifted[15:0]};
			end
			LW: begin
				data = shifted;
			end
			default: begin
				// reserved encodings read the whole word
				data = shifted;
			end
		endcase
	end

endmodule

/* hdl/mem_wb_stage.sv */
// mem/wb stage holding the stage-3 register, memory request, aligners, csr and writeback

`include "rv_params.svh"

module mem_wb_stage import rv_pkg::*; (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             stall,
	input  ex_mem_t          ex_in,
	output dmem_req_t        dmem_req,
	input  logic [`XLEN-1:0] dmem_rdata,
	output wb_t              wb,
	output logic [`XLEN-1:0] csr_out
);

	// stage-3 state
	logic             s3_valid;
	logic [`XLEN-1:0] s3_inst;
	logic [`XLEN-1:0] s3_pc;
	logic [`XLEN-1:0] s3_alu;

	logic [3:0]       st_we;
	logic [`XLEN-1:0] st_wdata;
	logic [`XLEN-1:0] ld_data;
	logic             is_load;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s3_valid <= 1'b0;
		end else if (!stall) begin
			s3_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			s3_inst <= ex_in.inst;
			s3_pc   <= ex_in.pc;
			s3_alu  <= ex_in.alu_out;
		end
	end

	// memory is addressed from the incoming instruction
	store_align u_store_align (
		.inst       (ex_in.inst),
		.addr_lo    (ex_in.alu_out[1:0]),
		.store_data (ex_in.store_data),
		.we         (st_we),
		.wdata      (st_wdata)
	);

	assign is_load = (opcode_e'(ex_in.inst[6:0]) == LOAD);

	assign dmem_req.addr  = ex_in.alu_out;
	assign dmem_req.wdata = st_wdata;
	assign dmem_req.we    = stall ? 4'b0000 : st_we;
	assign dmem_req.re    = is_load && !stall;

	// csr write also happens as the instruction enters stage 3
	csr_file u_csr_file (
		.clk     (clk),
		.arst_n  (arst_n),
		.advance (!stall),
		.inst    (ex_in.inst),
		.rs1_val (ex_in.rs1_val),
		.csr     (csr_out)
	);

	load_align u_load_align (
		.inst    (s3_inst),
		.addr_lo (s3_alu[1:0]),
		.raw     (dmem_rdata),
		.data    (ld_data)
	);

	wb_select u_wb_select (
		.valid    (s3_valid),
		.inst     (s3_inst),
		.pc       (s3_pc),
		.alu_out  (s3_alu),
		.mem_data (ld_data),
		.data     (wb.data),
		.en       (wb.en)
	);

	assign wb.rd = s3_inst[11:7];

endmodule

/* hdl/mem_wb_top.sv */
// mem/wb top wires the stage-3 block to its data memory

`include "rv_params.svh"

module mem_wb_top import rv_pkg::*; (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             stall,
	input  ex_mem_t          ex_in,
	output wb_t              wb,
	output logic [`XLEN-1:0] csr_out
);

	dmem_req_t        dmem_req;
	logic [`XLEN-1:0] dmem_rdata;

	mem_wb_stage u_stage (
		.clk        (clk),
		.arst_n     (arst_n),
		.stall      (stall),
		.ex_in      (ex_in),
		.dmem_req   (dmem_req),
		.dmem_rdata (dmem_rdata),
		.wb         (wb),
		.csr_out    (csr_out)
	);

	// stands in for the dcache
	data_mem u_dmem (
		.clk   (clk),
		.req   (dmem_req),
		.rdata (dmem_rdata)
	);

endmodule

/* hdl/rv_params.svh */
// rv params hold the widths, data memory depth and csr address of the mem/wb stage

`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data and address width
`define XLEN 32

// data memory depth in words
`define DMEM_WORDS 1024

// the tohost csr is the only one kept here
`define CSR_TOHOST_ADDR 12'h51e

`endif

/* hdl/rv_pkg.sv */
// rv package with opcode and funct3 encodings plus stage structs for the mem/wb stage

`include "rv_params.svh"

package rv_pkg;

	// base opcodes in inst[6:0]
	typedef enum logic [6:0] {
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		SYSTEM = 7'b1110011
	} opcode_e;

	// load width and sign in inst[14:12]
	typedef enum logic [2:0] {
		LB  = 3'b000,
		LH  = 3'b001,
		LW  = 3'b010,
		LBU = 3'b100,
		LHU = 3'b101
	} load_f3_e;

	// store width in inst[14:12]
	typedef enum logic [2:0] {
		SB = 3'b000,
		SH = 3'b001,
		SW = 3'b010
	} store_f3_e;

	typedef enum logic [1:0] {
		WB_ALU  = 2'd0,
		WB_MEM  = 2'd1,
		WB_PC4  = 2'd2,
		WB_NONE = 2'd3
	} wb_sel_e;

	// what execute hands over each cycle
	typedef struct packed {
		logic [`XLEN-1:0] inst;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] alu_out;
		logic [`XLEN-1:0] store_data;
		logic [`XLEN-1:0] rs1_val;
	} ex_mem_t;

	typedef struct packed {
		logic [`XLEN-1:0] addr;
		logic [`XLEN-1:0] wdata;
		logic [3:0]       we;
		logic             re;
	} dmem_req_t;

	typedef struct packed {
		logic [`XLEN-1:0] data;
		logic [4:0]       rd;
		logic             en;
	} wb_t;

endpackage

/* hdl/store_align.sv */
// store align turns a store into byte enables and lane-replicated write data

`include "rv_params.svh"

module store_align import rv_pkg::*; (
	input  logic [`XLEN-1:0] inst,
	input  logic [1:0]       addr_lo,
	input  logic [`XLEN-1:0] store_data,
	output logic [3:0]       we,
	output logic [`XLEN-1:0] wdata
);

	opcode_e   opcode;
	store_f3_e f3;

	assign opcode = opcode_e'(inst[6:0]);
	assign f3     = store_f3_e'(inst[14:12]);

	always_comb begin
		we    = 4'b0000;
		wdata = store_data;
		if (opcode == STORE) begin
			case (f3)
				SB: begin
					// byte goes to every lane and the enable picks one
					we    = 4'b0001 << addr_lo;
					wdata = {4{store_data[7:0]}};
				end
				SH: begin
					we    = 4'b0011 << addr_lo;
					wdata = {2{store_data[15:0]}};
				end
				SW: begin
					we    = 4'b1111;
					wdata = store_data;
				end
				default: begin
					// reserved funct3 writes nothing
					we    = 4'b0000;
					wdata = store_data;
				end
			endcase
		end
	end

endmodule

/* hdl/wb_select.sv */
// wb select picks the writeback source from the opcode and muxes the data

`include "rv_params.svh"

module wb_select import rv_pkg::*; (
	input  logic             valid,
	input  logic [`XLEN-1:0] inst,
	input  logic [`XLEN-1:0] pc,
	input  logic [`XLEN-1:0] alu_out,
	input  logic [`XLEN-1:0] mem_data,
	output logic [`XLEN-1:0] data,
	output logic             en
);

	localparam logic [`XLEN-1:0] PC_STEP = 4;

	wb_sel_e          sel;
	logic [`XLEN-1:0] pc4;

	assign pc4 = pc + PC_STEP;

	always_comb begin
		case (opcode_e'(inst[6:0]))
			LOAD:                   sel = WB_MEM;
			JAL, JALR:              sel = WB_PC4;
			OP, OP_IMM, LUI, AUIPC: sel = WB_ALU;
			default:                sel = WB_NONE;
		endcase
	end

	always_comb begin
		case (sel)
			WB_MEM:  data = mem_data;
			WB_PC4:  data = pc4;
			default: data = alu_out;
		endcase
	end

	// x0 never gets written
	assign en = valid && (sel != WB_NONE) && (inst[11:7] != 5'd0);

endmodule

/* verification/tb_mem_wb.sv */
// mem/wb testbench checking instruction streams with stalls against a reference model

`include "rv_params.svh"

module tb_mem_wb import rv_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		wb_t              w;
		logic [`XLEN-1:0] csr;
	} exp_t;

	localparam int RESET_CYCLES  = 8;
	localparam int N_RANDOM      = 400;
	localparam int MAX_STALL     = 3;
	localparam int PREFILL_WORDS = 16;
	localparam logic [`XLEN-1:0] RAND_BASE = 32'h400;
	localparam int LDST_CYCLES   = 4 * 3 * 22;
	localparam int WB_CYCLES     = 8 * (1 + 1 + 3);
	localparam int CSR_CYCLES    = 8 * 2;
	localparam int RANDOM_CYCLES = PREFILL_WORDS + N_RANDOM * (1 + MAX_STALL);
	// four drains of two cycles and the reset check
	localparam int STIM_CYCLES = LDST_CYCLES + WB_CYCLES + CSR_CYCLES + RANDOM_CYCLES + 9;
	localparam int LIMIT = 3 * STIM_CYCLES + RESET_CYCLES;

	logic             clk;
	logic             arst_n;
	logic             stall;
	ex_mem_t          ex_in;
	wb_t              wb;
	logic [`XLEN-1:0] csr_out;

	logic [`XLEN-1:0] shadow_mem [int];
	logic [`XLEN-1:0] shadow_csr = '0;
	exp_t             exp_q [$];
	integer           seed = 32'h5d1;
	int               errors = 0;
	int               checks = 0;
	int               tests_done = 0;
	int               cycle_count;
	bit               s3_full = 1'b0;

	mem_wb_top dut (
		.clk     (clk),
		.arst_n  (arst_n),
		.stall   (stall),
		.ex_in   (ex_in),
		.wb      (wb),
		.csr_out (csr_out)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// moves the shadows by one instruction and returns its expected wb and csr
	function automatic exp_t predict(input ex_mem_t e);
		exp_t        r;
		logic [6:0]  opc;
		logic [2:0]  f3;
		int          idx;
		logic [1:0]  off;
		logic [31:0] word;
		logic [31:0] lanes;
		logic [31:0] sh;
		logic [3:0]  be;
		logic [31:0] ld;
		opc = e.inst[6:0];
		f3  = e.inst[14:12];
		idx = int'((e.alu_out >> 2) % `DMEM_WORDS);
		off = e.alu_out[1:0];
		word = shadow_mem.exists(idx) ? shadow_mem[idx] : 'x;
		sh = word >> (8 * off);
		case (f3)
			LB:      ld = {{24{sh[7]}}, sh[7:0]};
			LH:      ld = {{16{sh[15]}}, sh[15:0]};
			LBU:     ld = {24'd0, sh[7:0]};
			LHU:     ld = {16'd0, sh[15:0]};
			default: ld = sh;
		endcase
		if (opc == STORE) begin
			// data goes to every lane and the enables pick the bytes
			case (f3)
				SB: begin
					be    = 4'b0001 << off;
					lanes = {4{e.store_data[7:0]}};
				end
				SH: begin
					be    = 4'b0011 << off;
					lanes = {2{e.store_data[15:0]}};
				end
				SW: begin
					be    = 4'b1111;
					lanes = e.store_data;
				end
				default: begin
					be    = 4'b0000;
					lanes = '0;
				end
			endcase
			for (int b = 0; b < 4; b++) begin
				if (be[b]) word[8*b +: 8] = lanes[8*b +: 8];
			end
			shadow_mem[idx] = word;
		end
		if (opc == SYSTEM && e.inst[31:20] == `CSR_TOHOST_ADDR) begin
			if (f3 == 3'b001) shadow_csr = e.rs1_val;
			else if (f3 == 3'b101) shadow_csr = {27'd0, e.inst[19:15]};
		end
		r.w.rd   = e.inst[11:7];
		r.w.en   = (e.inst[11:7] != 5'd0);
		r.w.data = '0;
		case (opc)
			LOAD:                   r.w.data = ld;
			JAL, JALR:              r.w.data = e.pc + 32'd4;
			OP, OP_IMM, LUI, AUIPC: r.w.data = e.alu_out;
			default:                r.w.en = 1'b0;
		endcase
		r.csr = shadow_csr;
		return r;
	endfunction

	function automatic ex_mem_t make_ex(input logic [6:0] opc, input logic [4:0] rd,
			input logic [2:0] f3, input logic [4:0] rs1, input logic [11:0] imm,
			input logic [31:0] alu, input logic [31:0] sd);
		ex_mem_t e;
		e.inst       = {imm, rs1, f3, rd, opc};
		e.pc         = $random(seed) & 32'hffff_fffc;
		e.alu_out    = alu;
		e.store_data = sd;
		e.rs1_val    = $random(seed);
		return e;
	endfunction

	function automatic ex_mem_t random_inst();
		logic [31:0] r;
		logic [31:0] addr;
		logic [2:0]  ld_f3 [5];
		logic [2:0]  st_f3 [3];
		r     = $random(seed);
		addr  = RAND_BASE + {26'd0, r[21:16]};
		ld_f3 = '{LB, LH, LW, LBU, LHU};
		st_f3 = '{SB, SH, SW};
		case (r[3:0])
			4'd0, 4'd1: return make_ex(OP, r[12:8], r[26:24], r[31:27], r[31:20],
				$random(seed), 0);
			4'd2, 4'd3: return make_ex(OP_IMM, r[12:8], r[26:24], r[31:27], r[31:20],
				$random(seed), 0);
			4'd4:       return make_ex(LUI, r[12:8], r[26:24], r[31:27], r[31:20],
				$random(seed), 0);
			4'd5:       return make_ex(AUIPC, r[12:8], r[26:24], r[31:27], r[31:20],
				$random(seed), 0);
			4'd6, 4'd7, 4'd8: return make_ex(LOAD, r[12:8], ld_f3[r[31:29] % 5], 5'd1, 12'd0,
				addr, 0);
			4'd9, 4'd10, 4'd11: return make_ex(STORE, r[12:8], st_f3[r[25:24] % 3], 5'd1, 12'd0,
				addr, $random(seed));
			4'd12:      return make_ex(JAL, r[12:8], r[26:24], r[31:27], r[31:20],
				$random(seed), 0);
			4'd13:      return make_ex(JALR, r[12:8], 3'b000, r[31:27], r[31:20],
				$random(seed), 0);
			4'd14:      return make_ex(BRANCH, r[12:8], r[26:24], r[31:27], r[31:20],
				$random(seed), 0);
			default:    return make_ex(SYSTEM, r[12:8], r[24] ? 3'b101 : (r[25] ? 3'b010 : 3'b001),
				r[31:27], r[26] ? `CSR_TOHOST_ADDR : 12'h340, 0, 0);
		endcase
	endfunction

	function automatic logic [31:0] fill_value(input logic [31:0] a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h6b2d_93e1;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("Mismatch at %0t ns: %s expected %h got %h", $time, name, expected, actual);
		errors++;
	endtask

	// stalled cycles with e already presented come before the take
	task automatic issue(input ex_mem_t e, input int n_stall);
		repeat (n_stall) begin
			@(negedge clk);
			stall = 1'b1;
			ex_in = e;
		end
		@(negedge clk);
		stall = 1'b0;
		ex_in = e;
		exp_q.push_back(predict(e));
	endtask

	task automatic hold();
		@(negedge clk);
		stall = 1'b1;
	endtask

	// a bubble pushes the last instruction out of stage 3
	task automatic drain();
		ex_mem_t bubble;
		bubble      = '0;
		bubble.inst = {25'd0, OP_IMM};
		issue(bubble, 0);
		hold();
	endtask

	task automatic test_done(input string name, input int err0);
		tests_done++;
		$display("test %0d, %s: %0d errors", tests_done, name, errors - err0);
	endtask

	task automatic end_run(input bit timed_out);
		$display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
		if (timed_out || errors != 0) begin
			$display("Result: FAILED");
		end else begin
			$display("Result: PASSED");
		end
		$finish;
	endtask

	// retirement at every unstalled edge once stage 3 holds something
	always @(posedge clk) begin : compare
		exp_t e;
		if (arst_n && !stall) begin
			if (s3_full) begin
				if (exp_q.size() == 0) begin
					$display("error at %0t ns: instruction retired with nothing expected", $time);
					errors++;
				end else begin
					e = exp_q.pop_front();
					checks++;
					if (wb.en !== e.w.en) report_mismatch("wb.en", e.w.en, wb.en);
					if (wb.rd !== e.w.rd) report_mismatch("wb.rd", e.w.rd, wb.rd);
					if (e.w.en && wb.data !== e.w.data) begin
						report_mismatch("wb.data", e.w.data, wb.data);
					end
					if (csr_out !== e.csr) report_mismatch("csr_out", e.csr, csr_out);
				end
			end
			s3_full = 1'b1;
		end
	end

	task automatic load_store_sweep();
		int          err0;
		logic [31:0] base;
		logic [31:0] data;
		logic [2:0]  st_f3;
		logic [2:0]  ld_f3 [5];
		err0  = errors;
		ld_f3 = '{LW, LH, LHU, LB, LBU};
		for (int off = 0; off < 4; off++) begin
			base = 32'h100 + 16 * off;
			for (int kind = 0; kind < 3; kind++) begin
				st_f3 = (kind == 0) ? SW : ((kind == 1) ? SH : SB);
				data  = $random(seed);
				// odd offsets get negative bytes
				data = (off % 2 == 1) ? (data | 32'h8080_8080) : (data & 32'h7f7f_7f7f);
				issue(make_ex(STORE, 5'd0, SW, 5'd1, 12'd0, base, fill_value(base)), 0);
				issue(make_ex(STORE, 5'd0, st_f3, 5'd1, 12'd0, base + off, data), 0);
				for (int lo = 0; lo < 4; lo++) begin
					for (int k = 0; k < 5; k++) begin
						issue(make_ex(LOAD, 5'(1 + (lo * 5 + k) % 31), ld_f3[k], 5'd1, 12'd0,
							base + lo, 0), 0);
					end
				end
			end
		end
		drain();
		test_done("loads and stores at every offset", err0);
	endtask

	task automatic writeback_sources();
		int         err0;
		logic [6:0] opcs [8];
		logic [4:0] rd;
		err0 = errors;
		opcs = '{OP, OP_IMM, LUI, AUIPC, JAL, JALR, BRANCH, STORE};
		// nonzero rd, then rd 0, then nonzero rd with stalls
		for (int rep = 0; rep < 3; rep++) begin
			for (int i = 0; i < 8; i++) begin
				rd = (rep == 1) ? 5'd0 : 5'(1 + i * 3 + rep);
				issue(make_ex(opcs[i], rd, SW, 5'(i), 12'(i),
					(opcs[i] == STORE) ? 32'h200 + 4 * i : $random(seed), $random(seed)),
					(rep == 2) ? 2 : 0);
			end
		end
		drain();
		test_done("writeback sources", err0);
	endtask

	task automatic tohost_writes();
		int          err0;
		logic [11:0] addrs [8];
		logic [2:0]  f3s [8];
		err0  = errors;
		addrs = '{`CSR_TOHOST_ADDR, `CSR_TOHOST_ADDR, 12'h340, 12'h305,
			`CSR_TOHOST_ADDR, `CSR_TOHOST_ADDR, 12'h7c0, `CSR_TOHOST_ADDR};
		f3s   = '{3'b001, 3'b101, 3'b001, 3'b101, 3'b010, 3'b001, 3'b001, 3'b101};
		for (int i = 0; i < 8; i++) begin
			issue(make_ex(SYSTEM, 5'(i + 1), f3s[i], 5'($random(seed)), addrs[i], 0, 0), 0);
			hold();
			checks++;
			if (csr_out !== shadow_csr) report_mismatch("csr_out", shadow_csr, csr_out);
		end
		drain();
		test_done("tohost csr writes", err0);
	endtask

	task automatic random_mix();
		int err0;
		int n_stall;
		err0 = errors;
		// every word the loads can reach gets a known value first
		for (int w = 0; w < PREFILL_WORDS; w++) begin
			issue(make_ex(STORE, 5'd0, SW, 5'd1, 12'd0, RAND_BASE + 4 * w,
				fill_value(RAND_BASE + 4 * w)), 0);
		end
		for (int i = 0; i < N_RANDOM; i++) begin
			n_stall = (($random(seed) & 3) == 0) ? 1 + ({$random(seed)} % MAX_STALL) : 0;
			issue(random_inst(), n_stall);
		end
		drain();
		if (exp_q.size() != 1) begin
			$display("error: %0d instructions never retired", exp_q.size() - 1);
			errors++;
		end
		test_done("random mix with stalls", err0);
	endtask

	initial begin
		int err0;
		arst_n = 1'b0;
		stall  = 1'b1;
		ex_in  = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;
		err0   = errors;
		@(negedge clk);
		checks++;
		if (wb.en !== 1'b0) report_mismatch("wb.en", 0, wb.en);
		checks++;
		if (csr_out !== '0) report_mismatch("csr_out", 0, csr_out);
		test_done("state after reset", err0);
		load_store_sweep();
		writeback_sources();
		tohost_writes();
		random_mix();
		end_run(1'b0);
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: run stopped after %0d cycles", cycle_count);
		end_run(1'b1);
	end

endmodule
